// ==== verilog/mlpNet_settings.svh ====
`ifndef MLPNET_SETTINGS_SVH
`define MLPNET_SETTINGS_SVH

// ========================================
// network shape
// ========================================

`define NUM_INPUTS 8 // features per sample
`define NUM_HIDDEN 6 // hidden neurons
`define NUM_OUTPUTS 4 // output neurons and classes

// ========================================
// arithmetic
// ========================================

`define DATA_WIDTH 16 // activations, weights and sums
`define CLASS_WIDTH 2 // index of one of NUM_OUTPUTS

`endif

// ==== verilog/mlpPkg.sv ====
`include "mlpNet_settings.svh"

package mlpPkg;

	// ========================================
	// words and vectors
	// ========================================

	typedef logic [`DATA_WIDTH-1:0] dataWord; // activation, modulo 2^16
	typedef logic signed [`DATA_WIDTH-1:0] coefWord; // weight or bias

	typedef dataWord [`NUM_INPUTS-1:0] featureVec; // one sample
	typedef dataWord [`NUM_HIDDEN-1:0] hiddenVec;
	typedef dataWord [`NUM_OUTPUTS-1:0] scoreVec; // output activations

	typedef enum logic
	{
		hiddenLayer = 1'b0,
		outputLayer = 1'b1
	} layerId;

	// winning class and its score, kept side by side
	typedef struct packed
	{
		logic [`CLASS_WIDTH-1:0] idx;
		dataWord value;
	} classPick;

	typedef struct packed
	{
		scoreVec scores; // output layer, aligned with class
		logic [`CLASS_WIDTH-1:0] classIdx;
		dataWord maxScore;
		hiddenVec hiddenAct; // hidden layer, aligned with class
	} netResult;

	// ========================================
	// coefficient rules
	// ========================================

	// weights spread over -8..8 so every neuron differs
	function automatic coefWord weightOf(
		input layerId layer,
		input int node,
		input int idx
	);
		int raw;
		raw = (int'(layer) * 31 + node * 7 + idx * 13) % 17;
		return coefWord'(raw - 8);
	endfunction

	// bias in -3..3
	function automatic coefWord biasOf(
		input layerId layer,
		input int node
	);
		int raw;
		raw = (int'(layer) * 3 + node * 5) % 7;
		return coefWord'(raw - 3);
	endfunction

endpackage

// ==== verilog/neuronNode.sv ====
`timescale 1ns/1ns
`include "mlpNet_settings.svh"

module neuronNode
	import mlpPkg::*;
#(
	parameter int FAN_IN = `NUM_INPUTS,
	parameter layerId LAYER = hiddenLayer,
	parameter int NODE = 0
)
(
	input logic clk,
	input logic reset,
	input dataWord [FAN_IN-1:0] inputs,
	output dataWord activation
);

	localparam coefWord BIAS = biasOf(LAYER, NODE);

	dataWord [FAN_IN-1:0] inputsReg; // stage 1
	dataWord [FAN_IN-1:0] products;
	dataWord sumNext;
	dataWord sumReg; // stage 2
	dataWord reluOut;

	// ========================================
	// weighted inputs
	// ========================================

	for (genvar i = 0; i < FAN_IN; i++)
	begin : gProduct
		localparam coefWord WEIGHT = weightOf(LAYER, NODE, i);

		assign products[i] = inputsReg[i] * WEIGHT; // low 16 bits kept
	end

	// ========================================
	// sum and activation
	// ========================================

	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < FAN_IN; i++)
		begin
			sumNext = sumNext + products[i]; // wraps like the adder chain
		end
	end

	// ReLU on the sign bit of the wrapped sum
	always_comb
	begin
		if (sumReg[`DATA_WIDTH-1])
		begin
			reluOut = '0;
		end
		else
		begin
			reluOut = sumReg;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inputsReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inputsReg <= inputs;
			sumReg <= sumNext;
			activation <= reluOut; // stage 3
		end
	end

endmodule

// ==== verilog/denseLayer.sv ====
`timescale 1ns/1ns
`include "mlpNet_settings.svh"

module denseLayer
	import mlpPkg::*;
#(
	parameter int FAN_IN = `NUM_INPUTS,
	parameter int FAN_OUT = `NUM_HIDDEN,
	parameter layerId LAYER = hiddenLayer
)
(
	input logic clk,
	input logic reset,
	input dataWord [FAN_IN-1:0] inputs,
	output dataWord [FAN_OUT-1:0] outputs
);

	// ========================================
	// neuron array
	// ========================================

	// every neuron sees the whole input vector
	// and takes its own weights from the rule by index
	for (genvar n = 0; n < FAN_OUT; n++)
	begin : gNode
		neuronNode #(
			.FAN_IN(FAN_IN),
			.LAYER(LAYER),
			.NODE(n)
		) node (
			.clk(clk),
			.reset(reset),
			.inputs(inputs),
			.activation(outputs[n]) // slot n of the layer vector
		);
	end

endmodule

// ==== verilog/classArgmax.sv ====
`timescale 1ns/1ns
`include "mlpNet_settings.svh"

module classArgmax
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input scoreVec scores,
	output logic [`CLASS_WIDTH-1:0] classIdx,
	output dataWord maxScore,
	output scoreVec scoresOut
);

	classPick best;
	classPick bestReg;

	// ========================================
	// compare
	// ========================================

	// scores come out of ReLU so unsigned compare is enough
	always_comb
	begin
		best.idx = '0;
		best.value = scores[0];
		for (int i = 1; i < `NUM_OUTPUTS; i++)
		begin
			if (scores[i] > best.value) // strict so ties keep lower index
			begin
				best.idx = `CLASS_WIDTH'(i);
				best.value = scores[i];
			end
		end
	end

	// ========================================
	// output register
	// ========================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			bestReg <= '0;
			scoresOut <= '0;
		end
		else
		begin
			bestReg <= best;
			scoresOut <= scores; // same cycle as the pick
		end
	end

	assign classIdx = bestReg.idx;
	assign maxScore = bestReg.value;

endmodule

// ==== verilog/mlpNet.sv ====
`timescale 1ns/1ns
`include "mlpNet_settings.svh"

module mlpNet
	import mlpPkg::*;
(
	input logic clk,
	input logic reset,
	input featureVec features,
	output netResult result
);

	localparam int HIDDEN_DELAY = 4; // output layer 3 plus argmax 1

	hiddenVec hiddenOut;
	scoreVec scores;
	scoreVec scoresOut;
	logic [`CLASS_WIDTH-1:0] classIdx;
	dataWord maxScore;
	hiddenVec hiddenPipe [HIDDEN_DELAY];

	// ========================================
	// layer chain
	// ========================================

	denseLayer #(
		.FAN_IN(`NUM_INPUTS),
		.FAN_OUT(`NUM_HIDDEN),
		.LAYER(hiddenLayer)
	) hidden (
		.clk(clk),
		.reset(reset),
		.inputs(features),
		.outputs(hiddenOut)
	);

	denseLayer #(
		.FAN_IN(`NUM_HIDDEN),
		.FAN_OUT(`NUM_OUTPUTS),
		.LAYER(outputLayer)
	) outputs (
		.clk(clk),
		.reset(reset),
		.inputs(hiddenOut),
		.outputs(scores)
	);

	classArgmax argmax (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.classIdx(classIdx),
		.maxScore(maxScore),
		.scoresOut(scoresOut)
	);

	// ========================================
	// hidden activation alignment
	// ========================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < HIDDEN_DELAY; i++)
			begin
				hiddenPipe[i] <= '0;
			end
		end
		else
		begin
			hiddenPipe[0] <= hiddenOut;
			for (int i = 1; i < HIDDEN_DELAY; i++)
			begin
				hiddenPipe[i] <= hiddenPipe[i-1];
			end
		end
	end

	always_comb
	begin
		result.scores = scoresOut;
		result.classIdx = classIdx;
		result.maxScore = maxScore;
		result.hiddenAct = hiddenPipe[HIDDEN_DELAY-1]; // same sample as the class
	end

endmodule

// ==== test/mlpNetModel.svh ====
`ifndef MLPNETMODEL_SVH
`define MLPNETMODEL_SVH

`include "mlpNet_settings.svh"

// ========================================
// random numbers
// ========================================

logic [31:0] lcgState; // advanced by every draw

function automatic logic [31:0] nextRandom();
	lcgState = lcgState * 32'd1664525 + 32'd1013904223;
	return lcgState;
endfunction

// ========================================
// reference arithmetic
// ========================================

// one neuron, accumulated in int and cut to a word at the end
function automatic dataWord neuronModel(
	input layerId layer,
	input int node,
	input int fanIn,
	input dataWord vals [`NUM_INPUTS]
);
	int acc;
	dataWord sum;
	acc = int'(biasOf(layer, node));
	for (int i = 0; i < fanIn; i++)
	begin
		acc += int'($signed(vals[i])) * int'(weightOf(layer, node, i));
	end
	sum = dataWord'(acc); // low bits equal the sum mod 2^16
	if (sum[`DATA_WIDTH-1])
	begin
		return '0; // ReLU
	end
	return sum;
endfunction

function automatic hiddenVec hiddenModel(input featureVec sample);
	dataWord vals [`NUM_INPUTS];
	hiddenVec act;
	for (int i = 0; i < `NUM_INPUTS; i++)
	begin
		vals[i] = sample[i];
	end
	for (int n = 0; n < `NUM_HIDDEN; n++)
	begin
		act[n] = neuronModel(hiddenLayer, n, `NUM_INPUTS, vals);
	end
	return act;
endfunction

function automatic scoreVec scoreModel(input hiddenVec hidden);
	dataWord vals [`NUM_INPUTS];
	scoreVec act;
	for (int i = 0; i < `NUM_INPUTS; i++)
	begin
		vals[i] = '0; // unused tail
	end
	for (int i = 0; i < `NUM_HIDDEN; i++)
	begin
		vals[i] = hidden[i];
	end
	for (int n = 0; n < `NUM_OUTPUTS; n++)
	begin
		act[n] = neuronModel(outputLayer, n, `NUM_HIDDEN, vals);
	end
	return act;
endfunction

// first index reaching the maximum wins
function automatic logic [`CLASS_WIDTH-1:0] argmaxModel(input scoreVec scores);
	int best;
	best = 0;
	for (int i = 1; i < `NUM_OUTPUTS; i++)
	begin
		if (scores[i] > scores[best])
		begin
			best = i;
		end
	end
	return `CLASS_WIDTH'(best);
endfunction

function automatic netResult netModel(input featureVec sample);
	netResult r;
	r.hiddenAct = hiddenModel(sample);
	r.scores = scoreModel(r.hiddenAct);
	r.classIdx = argmaxModel(r.scores);
	r.maxScore = r.scores[r.classIdx];
	return r;
endfunction

`endif

// ==== test/mlpNetTb.sv ====
`timescale 1ns/1ns
`include "mlpNet_settings.svh"

module mlpNetTb
	import mlpPkg::*;
;

	localparam int HALF_PERIOD = 50;
	localparam int CLK_PERIOD = 2 * HALF_PERIOD;
	localparam int DRIVE_DELAY = 1; // after the rising edge
	localparam int PIPE_DEPTH = 7; // sample edge to result edge
	localparam logic [31:0] SEED = 32'hb186;
	localparam int RESET_CYCLES = 10;
	localparam int MID_RESET_CYCLES = 5;
	localparam int NUM_RANDOM = 2000;
	localparam int NUM_SMALL = 500;
	localparam int NUM_ZERO = 20;
	localparam int NUM_BEFORE_RESET = 100;
	localparam int NUM_AFTER_RESET = 300;
	localparam int NUM_SAMPLES = NUM_RANDOM + NUM_SMALL + NUM_ZERO
		+ NUM_BEFORE_RESET + NUM_AFTER_RESET;
	localparam int TIMEOUT_CYCLES = NUM_SAMPLES + RESET_CYCLES + MID_RESET_CYCLES + 20;

	typedef logic [127:0] wideWord;

	logic clk;
	logic reset;
	featureVec features;
	netResult result;

	netResult expectQ [$]; // one entry per sample in flight
	int errors;
	int checks;
	int ties;

	`include "mlpNetModel.svh"

	mlpNet dut (
		.clk(clk),
		.reset(reset),
		.features(features),
		.result(result)
	);

	always #HALF_PERIOD clk = ~clk;

	// ========================================
	// stimulus helpers
	// ========================================

	function automatic featureVec randomFeatures(input bit smallRange);
		featureVec f;
		for (int i = 0; i < `NUM_INPUTS; i++)
		begin
			if (smallRange)
			begin
				f[i] = dataWord'(nextRandom() >> 30); // 0..3
			end
			else
			begin
				f[i] = dataWord'(nextRandom() >> 16);
			end
		end
		return f;
	endfunction

	// zero features leave only the bias in every hidden sum
	function automatic netResult zeroVectorExpected();
		netResult r;
		coefWord bias;
		for (int n = 0; n < `NUM_HIDDEN; n++)
		begin
			bias = biasOf(hiddenLayer, n);
			if (bias < 0)
			begin
				r.hiddenAct[n] = '0;
			end
			else
			begin
				r.hiddenAct[n] = dataWord'(bias);
			end
		end
		r.scores = scoreModel(r.hiddenAct);
		r.classIdx = argmaxModel(r.scores);
		r.maxScore = r.scores[r.classIdx];
		return r;
	endfunction

	function automatic bit hasTie(input scoreVec scores, input logic [`CLASS_WIDTH-1:0] idx);
		for (int i = 0; i < `NUM_OUTPUTS; i++)
		begin
			if (i != int'(idx) && scores[i] == scores[idx])
			begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// ========================================
	// checking
	// ========================================

	task automatic checkField(input string name, input wideWord expected, input wideWord actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("error: %s expected %0h got %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic compareResult(input netResult expected);
		checkField("result.hiddenAct", wideWord'(expected.hiddenAct), wideWord'(result.hiddenAct));
		checkField("result.scores", wideWord'(expected.scores), wideWord'(result.scores));
		checkField("result.classIdx", wideWord'(expected.classIdx), wideWord'(result.classIdx));
		checkField("result.maxScore", wideWord'(expected.maxScore), wideWord'(result.maxScore));
	endtask

	task automatic driveSample(input featureVec sample, input netResult expected);
		netResult oldest;
		@(posedge clk);
		#DRIVE_DELAY;
		if (expectQ.size() == PIPE_DEPTH)
		begin
			oldest = expectQ.pop_front();
			compareResult(oldest); // sample driven 7 edges ago
		end
		features = sample;
		expectQ.push_back(expected);
		if (hasTie(expected.scores, expected.classIdx))
		begin
			ties++;
		end
	endtask

	task automatic runSamples(input int count, input bit smallRange);
		featureVec sample;
		repeat (count)
		begin
			sample = randomFeatures(smallRange);
			driveSample(sample, netModel(sample));
		end
	endtask

	// pipeline contents are lost and the result stays zero
	task automatic applyReset(input int cycles);
		netResult cleared;
		cleared = '0;
		@(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b1;
		features = '0;
		expectQ.delete();
		repeat (cycles)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			compareResult(cleared);
		end
		reset = 1'b0;
	endtask

	task automatic drainPipeline();
		netResult oldest;
		while (expectQ.size() > 0)
		begin
			@(posedge clk);
			#DRIVE_DELAY;
			oldest = expectQ.pop_front();
			compareResult(oldest);
		end
	endtask

	// ========================================
	// test sequence
	// ========================================

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		features = '0;
		errors = 0;
		checks = 0;
		ties = 0;
		lcgState = SEED;

		applyReset(RESET_CYCLES);
		runSamples(NUM_RANDOM, 1'b0); // full range, wraps often
		runSamples(NUM_SMALL, 1'b1); // many zero scores and ties
		repeat (NUM_ZERO)
		begin
			driveSample('0, zeroVectorExpected());
		end
		runSamples(NUM_BEFORE_RESET, 1'b0);
		applyReset(MID_RESET_CYCLES);
		runSamples(NUM_AFTER_RESET, 1'b0);
		drainPipeline();

		assert (ties > 0)
		else
		begin
			$display("no sample produced tied class scores so the tie rule was never exercised");
			errors++;
		end

		$display("errors: %0d, checks: %0d, ties seen: %0d", errors, checks, ties);
		if (errors == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== mlpNet.f ====
+incdir+verilog
+incdir+test
verilog/mlpPkg.sv
verilog/neuronNode.sv
verilog/denseLayer.sv
verilog/classArgmax.sv
verilog/mlpNet.sv
test/mlpNetTb.sv

// ==== Makefile ====
# Verilator build for the MLP inference pipeline

VERILATOR ?= verilator
TOP ?= mlpNetTb
RTL_TOP ?= mlpNet
FILELIST ?= mlpNet.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert --timescale 1ns/1ns

RTL_SRCS ?= verilog/mlpPkg.sv verilog/neuronNode.sv verilog/denseLayer.sv \
	verilog/classArgmax.sv verilog/mlpNet.sv

SOURCES := $(wildcard verilog/*.sv verilog/*.svh test/*.sv test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) +incdir+verilog --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
